// File: hdl/udp_echo_defines.svh
`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// Payload path widths
`define UDP_DATA_W 64
`define UDP_KEEP_W 8

// Payload FIFO depth in beats, power of two
`define ECHO_FIFO_DEPTH 16

// Configuration port
`define CFG_ADDR_W 2

// 192.168.1.128
`define CFG_LOCAL_IP_RST 32'hc0a8_0180

`define CFG_ECHO_PORT_RST 16'd1234

`define CFG_TTL_RST 8'd64

// Status output
`define LED_W 8

`endif

// File: hdl/udp_pkg.sv
`include "udp_echo_defines.svh"

package udp_pkg;

    // Parsed UDP header as delivered by the receive stack
    typedef struct packed {
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [7:0]  ip_ttl;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload word with its sideband
    typedef struct packed {
        logic [`UDP_DATA_W-1:0] data;
        logic [`UDP_KEEP_W-1:0] keep;
        logic                   last;
        // Set by the receive stack on a bad frame
        logic                   user;
    } pay_beat_t;

endpackage

// File: hdl/echo_cfg_pkg.sv
`include "udp_echo_defines.svh"

package echo_cfg_pkg;

    // Register addresses on the configuration write port
    localparam logic [`CFG_ADDR_W-1:0] CFG_ADDR_LOCAL_IP  = 'd0;
    localparam logic [`CFG_ADDR_W-1:0] CFG_ADDR_ECHO_PORT = 'd1;
    localparam logic [`CFG_ADDR_W-1:0] CFG_ADDR_TTL       = 'd2;

    typedef struct packed {
        logic [31:0] local_ip;
        logic [15:0] echo_port;
        logic [7:0]  ttl;
    } echo_cfg_t;

endpackage

// File: hdl/echo_cfg_regs.sv
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module echo_cfg_regs
    import echo_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cfg_we,
    input  logic [`CFG_ADDR_W-1:0] cfg_addr,
    input  logic [31:0]            cfg_wdata,
    output echo_cfg_t              cfg
);

    echo_cfg_t cfg_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q.local_ip  <= `CFG_LOCAL_IP_RST;
            cfg_q.echo_port <= `CFG_ECHO_PORT_RST;
            cfg_q.ttl       <= `CFG_TTL_RST;
        end else if (cfg_we) begin
            // One field per address, narrow fields take the low bits
            case (cfg_addr)
                CFG_ADDR_LOCAL_IP: begin
                    cfg_q.local_ip <= cfg_wdata;
                end
                CFG_ADDR_ECHO_PORT: begin
                    cfg_q.echo_port <= cfg_wdata[15:0];
                end
                CFG_ADDR_TTL: begin
                    cfg_q.ttl <= cfg_wdata[7:0];
                end
                default: begin
                    // Unmapped address
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    assign cfg = cfg_q;

endmodule

// File: hdl/udp_port_filter.sv
`timescale 1ns/1ps

module udp_port_filter
    import udp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] cfg_echo_port,
    input  udp_hdr_t    s_hdr,
    input  logic        s_hdr_valid,
    output logic        s_hdr_ready,
    input  pay_beat_t   s_pay,
    input  logic        s_pay_valid,
    output logic        s_pay_ready,
    output udp_hdr_t    fwd_hdr,
    output logic        fwd_hdr_valid,
    input  logic        fwd_hdr_ready,
    output pay_beat_t   fifo_in,
    output logic        fifo_in_valid,
    input  logic        fifo_in_ready
);

    // Frame state
    logic in_frame;
    logic matched;

    logic fwd_free;
    logic hdr_xfer;
    logic hdr_match;
    logic pay_xfer;

    // Forward register can take a header when empty or emptying
    assign fwd_free  = !fwd_hdr_valid || fwd_hdr_ready;
    assign s_hdr_ready = !in_frame && fwd_free;
    assign hdr_xfer  = s_hdr_valid && s_hdr_ready;
    assign hdr_match = (s_hdr.dst_port == cfg_echo_port);

    // Matched payload goes to the FIFO, anything else is drained
    assign fifo_in       = s_pay;
    assign fifo_in_valid = s_pay_valid && in_frame && matched;
    assign s_pay_ready   = in_frame && (matched ? fifo_in_ready : 1'b1);
    assign pay_xfer      = s_pay_valid && s_pay_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            matched  <= 1'b0;
        end else if (hdr_xfer) begin
            in_frame <= 1'b1;
            matched  <= hdr_match;
        end else if (pay_xfer && s_pay.last) begin
            in_frame <= 1'b0;
            matched  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_hdr_valid <= 1'b0;
        end else if (hdr_xfer && hdr_match) begin
            fwd_hdr_valid <= 1'b1;
        end else if (fwd_hdr_ready) begin
            fwd_hdr_valid <= 1'b0;
        end
    end

    // Header payload register
    always_ff @(posedge clk) begin
        if (hdr_xfer && hdr_match) begin
            fwd_hdr <= s_hdr;
        end
    end

endmodule

// File: hdl/payload_fifo.sv
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module payload_fifo
    import udp_pkg::*;
#(
    parameter int DEPTH = `ECHO_FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  pay_beat_t in_beat,
    input  logic      in_valid,
    output logic      in_ready,
    output pay_beat_t out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    localparam int AW = $clog2(DEPTH);

    pay_beat_t mem [DEPTH];

    // Extra MSB tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in_ready = !full;
    assign wr_en    = in_valid && !full;
    // Refill output register when it is empty or being taken
    assign rd_en    = !empty && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr[AW-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/echo_tx_port.sv
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module echo_tx_port
    import udp_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       cfg_local_ip,
    input  logic [7:0]        cfg_ttl,
    input  udp_hdr_t          fwd_hdr,
    input  logic              fwd_hdr_valid,
    output logic              fwd_hdr_ready,
    input  pay_beat_t         pay_in,
    input  logic              pay_in_valid,
    output logic              pay_in_ready,
    output udp_hdr_t          m_hdr,
    output logic              m_hdr_valid,
    input  logic              m_hdr_ready,
    output pay_beat_t         m_pay,
    output logic              m_pay_valid,
    input  logic              m_pay_ready,
    output logic [`LED_W-1:0] led
);

    udp_hdr_t reply;
    logic     hdr_load;
    logic     pay_xfer;
    logic     sof;

    // Reply goes back to the sender with ports swapped
    always_comb begin
        reply          = fwd_hdr;
        reply.ip_src   = cfg_local_ip;
        reply.ip_dst   = fwd_hdr.ip_src;
        reply.ip_ttl   = cfg_ttl;
        reply.src_port = fwd_hdr.dst_port;
        reply.dst_port = fwd_hdr.src_port;
        reply.checksum = 16'd0;
    end

    // One-deep header register, refills as the old reply leaves
    assign fwd_hdr_ready = !m_hdr_valid || m_hdr_ready;
    assign hdr_load      = fwd_hdr_valid && fwd_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            m_hdr <= reply;
        end
    end

    // Payload straight through
    assign m_pay        = pay_in;
    assign m_pay_valid  = pay_in_valid;
    assign pay_in_ready = m_pay_ready;
    assign pay_xfer     = pay_in_valid && m_pay_ready;

    // First beat of each frame sets the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            sof <= 1'b1;
            led <= '0;
        end else if (pay_xfer) begin
            sof <= pay_in.last;
            if (sof) begin
                led <= pay_in.data[`LED_W-1:0];
            end
        end
    end

endmodule

// File: hdl/udp_echo_core.sv
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_echo_core
    import udp_pkg::*;
    import echo_cfg_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  udp_hdr_t               s_hdr,
    input  logic                   s_hdr_valid,
    output logic                   s_hdr_ready,
    input  pay_beat_t              s_pay,
    input  logic                   s_pay_valid,
    output logic                   s_pay_ready,
    output udp_hdr_t               m_hdr,
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output pay_beat_t              m_pay,
    output logic                   m_pay_valid,
    input  logic                   m_pay_ready,
    input  logic                   cfg_we,
    input  logic [`CFG_ADDR_W-1:0] cfg_addr,
    input  logic [31:0]            cfg_wdata,
    output logic [`LED_W-1:0]      led
);

    echo_cfg_t cfg;

    // Matched header from filter to transmit side
    udp_hdr_t  fwd_hdr;
    logic      fwd_hdr_valid;
    logic      fwd_hdr_ready;

    // Payload into and out of the FIFO
    pay_beat_t fifo_in;
    logic      fifo_in_valid;
    logic      fifo_in_ready;
    pay_beat_t fifo_out;
    logic      fifo_out_valid;
    logic      fifo_out_ready;

    echo_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    udp_port_filter u_filter (
        .clk           (clk),
        .rst           (rst),
        .cfg_echo_port (cfg.echo_port),
        .s_hdr         (s_hdr),
        .s_hdr_valid   (s_hdr_valid),
        .s_hdr_ready   (s_hdr_ready),
        .s_pay         (s_pay),
        .s_pay_valid   (s_pay_valid),
        .s_pay_ready   (s_pay_ready),
        .fwd_hdr       (fwd_hdr),
        .fwd_hdr_valid (fwd_hdr_valid),
        .fwd_hdr_ready (fwd_hdr_ready),
        .fifo_in       (fifo_in),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_ready (fifo_in_ready)
    );

    payload_fifo #(
        .DEPTH (`ECHO_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (fifo_in),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .out_beat  (fifo_out),
        .out_valid (fifo_out_valid),
        .out_ready (fifo_out_ready)
    );

    echo_tx_port u_tx (
        .clk           (clk),
        .rst           (rst),
        .cfg_local_ip  (cfg.local_ip),
        .cfg_ttl       (cfg.ttl),
        .fwd_hdr       (fwd_hdr),
        .fwd_hdr_valid (fwd_hdr_valid),
        .fwd_hdr_ready (fwd_hdr_ready),
        .pay_in        (fifo_out),
        .pay_in_valid  (fifo_out_valid),
        .pay_in_ready  (fifo_out_ready),
        .m_hdr         (m_hdr),
        .m_hdr_valid   (m_hdr_valid),
        .m_hdr_ready   (m_hdr_ready),
        .m_pay         (m_pay),
        .m_pay_valid   (m_pay_valid),
        .m_pay_ready   (m_pay_ready),
        .led           (led)
    );

endmodule

// File: verif/udp_echo_properties.sv
`timescale 1ns/1ps

module udp_echo_properties
    import udp_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      s_hdr_valid,
    input logic      s_hdr_ready,
    input pay_beat_t s_pay,
    input logic      s_pay_valid,
    input logic      s_pay_ready,
    input udp_hdr_t  m_hdr,
    input logic      m_hdr_valid,
    input logic      m_hdr_ready,
    input pay_beat_t m_pay,
    input logic      m_pay_valid,
    input logic      m_pay_ready
);

    // Frame tracking seen from the input streams
    logic frame_open;

    // Failed assertions so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open <= 1'b0;
        end else if (s_hdr_valid && s_hdr_ready) begin
            frame_open <= 1'b1;
        end else if (s_pay_valid && s_pay_ready && s_pay.last) begin
            frame_open <= 1'b0;
        end
    end

    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_hdr))
        else begin
            fail_count++;
            $error("m_hdr dropped or changed before m_hdr_ready");
        end

    a_pay_hold: assert property (@(posedge clk) disable iff (rst)
        m_pay_valid && !m_pay_ready |=> m_pay_valid && $stable(m_pay))
        else begin
            fail_count++;
            $error("m_pay dropped or changed before m_pay_ready");
        end

    // Outputs idle right after a reset cycle
    a_reset_idle: assert property (@(posedge clk)
        $past(rst) |-> !m_hdr_valid && !m_pay_valid)
        else begin
            fail_count++;
            $error("output valid high in the cycle after reset");
        end

    a_one_frame: assert property (@(posedge clk) disable iff (rst)
        frame_open |-> !s_hdr_ready)
        else begin
            fail_count++;
            $error("s_hdr_ready high while a frame is in progress");
        end

endmodule

// File: verif/udp_echo_tb.sv
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_echo_tb
    import udp_pkg::*;
    import echo_cfg_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_BEATS  = 8;
    localparam int MIX_FRAMES = 12;
    localparam int BP_FRAMES  = 20;
    localparam int CFG_FRAMES = 8;
    localparam int NUM_FRAMES = 1 + MIX_FRAMES + BP_FRAMES + CFG_FRAMES;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * MAX_BEATS * 40;

    logic clk;
    logic rst;
    udp_hdr_t s_hdr;
    logic s_hdr_valid;
    logic s_hdr_ready;
    pay_beat_t s_pay;
    logic s_pay_valid;
    logic s_pay_ready;
    udp_hdr_t m_hdr;
    logic m_hdr_valid;
    logic m_hdr_ready;
    pay_beat_t m_pay;
    logic m_pay_valid;
    logic m_pay_ready;
    logic cfg_we;
    logic [`CFG_ADDR_W-1:0] cfg_addr;
    logic [31:0] cfg_wdata;
    logic [`LED_W-1:0] led;

    integer seed = 32'hffb4_0a0a;
    integer bp_seed;
    bit bp_on;
    int value_errors;
    int other_errors;
    int frames_sent;
    int frames_echoed;

    // Expected output streams
    udp_hdr_t exp_hdr_q[$];
    pay_beat_t exp_beat_q[$];

    // Local copy of the configuration registers
    logic [31:0] tb_local_ip;
    logic [15:0] tb_echo_port;
    logic [7:0] tb_ttl;

    bit tb_sof = 1'b1;
    logic [`LED_W-1:0] led_exp = '0;

    udp_echo_core UUT (.*);

    bind udp_echo_core udp_echo_properties u_props (
        .clk(clk), .rst(rst),
        .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
        .s_pay(s_pay), .s_pay_valid(s_pay_valid), .s_pay_ready(s_pay_ready),
        .m_hdr(m_hdr), .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
        .m_pay(m_pay), .m_pay_valid(m_pay_valid), .m_pay_ready(m_pay_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reply expected for a received frame, none when the port differs
    function automatic bit echo_expect(input udp_hdr_t rx, input logic [31:0] local_ip,
                                       input logic [15:0] echo_port, input logic [7:0] ttl,
                                       output udp_hdr_t reply);
        reply = '0;
        if (rx.dst_port != echo_port) begin
            return 1'b0;
        end
        reply.ip_src   = local_ip;
        reply.ip_dst   = rx.ip_src;
        reply.ip_ttl   = ttl;
        reply.src_port = rx.dst_port;
        reply.dst_port = rx.src_port;
        reply.length   = rx.length;
        reply.checksum = 16'd0;
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [135:0] got,
                               input logic [135:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Echo port half the time, otherwise any other port
    function automatic logic [15:0] pick_port();
        logic [31:0] rnd;
        logic [15:0] other;
        rnd = $random(seed);
        other = rnd[31:16];
        if (other == tb_echo_port) begin
            other = other ^ 16'h1;
        end
        return rnd[0] ? tb_echo_port : other;
    endfunction

    function automatic int pick_len();
        logic [31:0] rnd;
        rnd = $random(seed);
        return 1 + int'(rnd[7:0]) % MAX_BEATS;
    endfunction

    task automatic send_frame(input logic [15:0] dst_port, input int nbeats);
        udp_hdr_t hdr;
        udp_hdr_t reply;
        pay_beat_t beat;
        logic [31:0] rnd;
        bit match;
        hdr.ip_src   = $random(seed);
        hdr.ip_dst   = tb_local_ip;
        hdr.ip_ttl   = $random(seed);
        hdr.src_port = $random(seed);
        hdr.dst_port = dst_port;
        hdr.length   = 16'(8 + 8 * nbeats);
        hdr.checksum = $random(seed);
        match = echo_expect(hdr, tb_local_ip, tb_echo_port, tb_ttl, reply);
        if (match) begin
            exp_hdr_q.push_back(reply);
        end
        @(negedge clk);
        s_hdr = hdr;
        s_hdr_valid = 1'b1;
        do @(posedge clk); while (!s_hdr_ready);
        for (int i = 0; i < nbeats; i++) begin
            rnd = $random(seed);
            beat.data = {$random(seed), $random(seed)};
            beat.last = (i == nbeats - 1);
            // Partial keep and error flag only on the closing beat
            beat.keep = beat.last ? (8'hff >> rnd[2:0]) : 8'hff;
            beat.user = beat.last && rnd[8] && rnd[9];
            if (match) begin
                exp_beat_q.push_back(beat);
            end
            @(negedge clk);
            s_hdr_valid = 1'b0;
            if (rnd[13:12] == 2'b00) begin
                s_pay_valid = 1'b0;
                @(negedge clk);
            end
            s_pay = beat;
            s_pay_valid = 1'b1;
            do @(posedge clk); while (!s_pay_ready);
        end
        @(negedge clk);
        s_pay_valid = 1'b0;
        frames_sent++;
    endtask

    task automatic write_cfg(input logic [`CFG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we = 1'b0;
        case (addr)
            2'd0: tb_local_ip = data;
            2'd1: tb_echo_port = data[15:0];
            2'd2: tb_ttl = data[7:0];
            default: ;
        endcase
    endtask

    task automatic wait_drained();
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        // Room for any stray output from dropped frames
        repeat (4) @(posedge clk);
    endtask

    // Output ready, random under back-pressure
    initial begin
        logic [31:0] rnd;
        bp_seed = seed ^ 32'h0000_5a5a;
        m_hdr_ready = 1'b0;
        m_pay_ready = 1'b0;
        forever begin
            @(negedge clk);
            rnd = $random(bp_seed);
            m_hdr_ready = bp_on ? rnd[2] : 1'b1;
            m_pay_ready = bp_on ? (rnd[1:0] != 2'b00) : 1'b1;
        end
    end

    always @(posedge clk) begin : compare_outputs
        udp_hdr_t exp_h;
        pay_beat_t exp_b;
        if (!rst) begin
            check_value("led", led, led_exp);
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    other_errors++;
                    $display("At %0t ns a reply header came out with no frame to echo", $time);
                end else begin
                    exp_h = exp_hdr_q.pop_front();
                    check_value("m_hdr", m_hdr, exp_h);
                    frames_echoed++;
                end
            end
            if (m_pay_valid && m_pay_ready) begin
                if (exp_beat_q.size() == 0) begin
                    other_errors++;
                    $display("At %0t ns a payload beat came out that was never sent", $time);
                end else begin
                    exp_b = exp_beat_q.pop_front();
                    check_value("m_pay.data", m_pay.data, exp_b.data);
                    check_value("m_pay.keep", m_pay.keep, exp_b.keep);
                    check_value("m_pay.last", m_pay.last, exp_b.last);
                    check_value("m_pay.user", m_pay.user, exp_b.user);
                    if (tb_sof) begin
                        led_exp = exp_b.data[`LED_W-1:0];
                    end
                    tb_sof = exp_b.last;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with replies still missing", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        s_hdr = '0;
        s_hdr_valid = 1'b0;
        s_pay = '0;
        s_pay_valid = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        bp_on = 1'b0;
        tb_local_ip = `CFG_LOCAL_IP_RST;
        tb_echo_port = `CFG_ECHO_PORT_RST;
        tb_ttl = `CFG_TTL_RST;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("m_hdr_valid", m_hdr_valid, 1'b0);
        check_value("m_pay_valid", m_pay_valid, 1'b0);
        check_value("led", led, '0);

        // Single frame with the default configuration
        send_frame(tb_echo_port, 3);
        wait_drained();

        // Mixed ports
        repeat (MIX_FRAMES) send_frame(pick_port(), pick_len());
        wait_drained();

        // Random back-pressure on both outputs
        bp_on = 1'b1;
        repeat (BP_FRAMES) send_frame(pick_port(), pick_len());
        wait_drained();

        // New configuration, old port now dropped
        write_cfg(CFG_ADDR_LOCAL_IP, 32'h0a00_0001);
        write_cfg(CFG_ADDR_ECHO_PORT, 32'hffff_1388);
        write_cfg(CFG_ADDR_TTL, 32'h0000_0111);
        write_cfg(2'd3, 32'hdead_beef);
        send_frame(16'd1234, 2);
        send_frame(tb_echo_port, 4);
        send_frame(16'd1234, 1);
        send_frame(tb_echo_port, 1);
        repeat (CFG_FRAMES - 4) send_frame(pick_port(), pick_len());
        wait_drained();
        bp_on = 1'b0;

        $display("Sent %0d frames, %0d echoed, %0d value errors, %0d other errors, %0d %s",
                 frames_sent, frames_echoed, value_errors, other_errors,
                 UUT.u_props.fail_count, "assertion errors");
        if (value_errors == 0 && other_errors == 0 && UUT.u_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: udp_echo_core.f
+incdir+hdl
hdl/udp_pkg.sv
hdl/echo_cfg_pkg.sv
hdl/echo_cfg_regs.sv
hdl/udp_port_filter.sv
hdl/payload_fifo.sv
hdl/echo_tx_port.sv
hdl/udp_echo_core.sv
verif/udp_echo_properties.sv
verif/udp_echo_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module udp_echo_tb -f udp_echo_core.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/Vudp_echo_tb > sim.log 2>&1
cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
